// File: dv/execCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module execCoreTb;
    import rvPkg::*;

    localparam int timeoutCycles = 40;

    typedef struct {
        string       name;
        logic [31:0] inst;
        logic [31:0] pc;
        opEnum       op;
        logic [31:0] rd;
        logic [31:0] value;
        logic [31:0] taken;
        logic [31:0] target;
    } vecT;

    logic        clk;
    logic        rstN;
    logic        inReq;
    logic [31:0] inInst;
    logic [31:0] inPc;
    logic        inAck;
    logic        outReq;
    logic        outAck;
    logic [5:0]  outOp;
    logic [4:0]  outRd;
    logic [31:0] outValue;
    logic        outTaken;
    logic [31:0] outTarget;

    vecT         vecs [$];
    logic [31:0] model [32]; // Expected register contents
    int          seed;
    int          acceptCount = 0;
    int          doneCount = 0;
    int          resultCount = 0;
    logic        inAckQ = 1'b0;
    logic        outReqQ = 1'b0;
    logic        outAckQ = 1'b0;

    execCore UUT (
        .clk       (clk),
        .rstN      (rstN),
        .inReq     (inReq),
        .inInst    (inInst),
        .inPc      (inPc),
        .inAck     (inAck),
        .outReq    (outReq),
        .outAck    (outAck),
        .outOp     (outOp),
        .outRd     (outRd),
        .outValue  (outValue),
        .outTaken  (outTaken),
        .outTarget (outTarget)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // RV32I instruction assembly
    function automatic logic [31:0] rType(input logic [6:0] f7, input logic [2:0] f3,
            input logic [31:0] rd, rs1, rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], 7'b0110011};
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] opc, input logic [2:0] f3,
            input logic [31:0] rd, rs1, imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] sType(input logic [2:0] f3, input logic [31:0] rs1, rs2, imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] bType(input logic [2:0] f3, input logic [31:0] rs1, rs2, imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] uType(input logic [6:0] opc, input logic [31:0] rd, imm);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jType(input logic [31:0] rd, imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
    endfunction

    // ALU ops, LUI, AUIPC, JAL and JALR write rd
    function automatic logic writesRd(input opEnum op);
        return (op inside {opLui, opAuipc, opJal, opJalr}) || (op >= opAddi && op <= opAnd);
    endfunction

    function automatic void addEntry(input string name, input logic [31:0] inst,
            input logic [31:0] pc, input opEnum op, input logic [31:0] rd,
            input logic [31:0] value, input logic [31:0] taken, input logic [31:0] target);
        vecT v;
        v.name   = name;
        v.inst   = inst;
        v.pc     = pc;
        v.op     = op;
        v.rd     = rd;
        v.value  = value;
        v.taken  = taken;
        v.target = target;
        vecs.push_back(v);
        if (writesRd(op) && rd != 0) model[rd[4:0]] = value;
    endfunction

    function automatic void buildTable();
        for (int r = 0; r < 32; r++) model[r] = '0;
        addEntry("addi x1", iType(opcodeArithI, 3'h0, 1, 0, 100), 0, opAddi, 1, 100, 0, 0);
        addEntry("addi x2", iType(opcodeArithI, 3'h0, 2, 0, -7), 0, opAddi, 2, -7, 0, 0);
        addEntry("addi x3", iType(opcodeArithI, 3'h0, 3, 0, 2047), 0, opAddi, 3, 32'h7FF, 0, 0);
        addEntry("addi x4", iType(opcodeArithI, 3'h0, 4, 0, -2048), 0, opAddi, 4, -2048, 0, 0);
        addEntry("addi x0", iType(opcodeArithI, 3'h0, 0, 0, 55), 0, opAddi, 0, 55, 0, 0);
        addEntry("addi x14", iType(opcodeArithI, 3'h0, 14, 0, 35), 0, opAddi, 14, 35, 0, 0);
        addEntry("add", rType(7'h00, 3'h0, 5, 1, 2), 0, opAdd, 5, 32'h5D, 0, 0);
        addEntry("sub", rType(7'h20, 3'h0, 6, 1, 2), 0, opSub, 6, 32'h6B, 0, 0);
        addEntry("slt", rType(7'h00, 3'h2, 7, 2, 1), 0, opSlt, 7, 1, 0, 0);
        addEntry("sltu", rType(7'h00, 3'h3, 8, 2, 1), 0, opSltu, 8, 0, 0, 0);
        addEntry("xor", rType(7'h00, 3'h4, 9, 1, 2), 0, opXor, 9, 32'hFFFFFF9D, 0, 0);
        addEntry("or", rType(7'h00, 3'h6, 10, 1, 2), 0, opOr, 10, 32'hFFFFFFFD, 0, 0);
        addEntry("and", rType(7'h00, 3'h7, 11, 1, 2), 0, opAnd, 11, 32'h60, 0, 0);
        addEntry("sll", rType(7'h00, 3'h1, 12, 1, 14), 0, opSll, 12, 32'h320, 0, 0);
        addEntry("srl", rType(7'h00, 3'h5, 13, 2, 14), 0, opSrl, 13, 32'h1FFFFFFF, 0, 0);
        addEntry("sra", rType(7'h20, 3'h5, 15, 2, 14), 0, opSra, 15, 32'hFFFFFFFF, 0, 0);
        addEntry("slli", iType(opcodeArithI, 3'h1, 16, 1, 4), 0, opSlli, 16, 32'h640, 0, 0);
        addEntry("srli", iType(opcodeArithI, 3'h5, 17, 2, 28), 0, opSrli, 17, 32'hF, 0, 0);
        addEntry("srai", iType(opcodeArithI, 3'h5, 18, 2, 32'h401), 0, opSrai, 18, -4, 0, 0);
        addEntry("lui", uType(opcodeLui, 19, 32'hABCDE), 0, opLui, 19, 32'hABCDE000, 0, 0);
        addEntry("auipc", uType(opcodeAuipc, 20, 32'h12345), 32'h40, opAuipc, 20,
                 32'h12345040, 0, 0);
        addEntry("jal", jType(21, 32'h800), 32'h1000, opJal, 21, 32'h1004, 1, 32'h1800);
        addEntry("jalr", iType(opcodeJalr, 3'h0, 22, 1, 7), 32'h200, opJalr, 22, 32'h204, 1,
                 32'h6A); // Bit 0 cleared
        addEntry("beq taken", bType(3'h0, 1, 1, 32'h800), 32'h3000, opBeq, 0, 0, 1, 32'h3800);
        addEntry("beq not", bType(3'h0, 1, 2, -16), 32'h3000, opBeq, 0, 0, 0, 32'h2FF0);
        addEntry("bne taken", bType(3'h1, 1, 2, -16), 32'h3000, opBne, 0, 0, 1, 32'h2FF0);
        addEntry("bne not", bType(3'h1, 2, 2, -16), 32'h3000, opBne, 0, 0, 0, 32'h2FF0);
        addEntry("blt taken", bType(3'h4, 2, 1, -16), 32'h3000, opBlt, 0, 0, 1, 32'h2FF0);
        addEntry("blt not", bType(3'h4, 1, 2, -16), 32'h3000, opBlt, 0, 0, 0, 32'h2FF0);
        addEntry("bge taken", bType(3'h5, 1, 2, -16), 32'h3000, opBge, 0, 0, 1, 32'h2FF0);
        addEntry("bge not", bType(3'h5, 2, 1, -16), 32'h3000, opBge, 0, 0, 0, 32'h2FF0);
        addEntry("bltu taken", bType(3'h6, 1, 2, -16), 32'h3000, opBltu, 0, 0, 1, 32'h2FF0);
        addEntry("bltu not", bType(3'h6, 2, 1, -16), 32'h3000, opBltu, 0, 0, 0, 32'h2FF0);
        addEntry("bgeu taken", bType(3'h7, 2, 1, -16), 32'h3000, opBgeu, 0, 0, 1, 32'h2FF0);
        addEntry("bgeu not", bType(3'h7, 1, 2, -16), 32'h3000, opBgeu, 0, 0, 0, 32'h2FF0);
        addEntry("lw", iType(opcodeLoad, 3'h2, 24, 1, -4), 0, opLw, 24, 32'h60, 0, 0);
        addEntry("lb", iType(opcodeLoad, 3'h0, 25, 2, 2047), 0, opLb, 25, 32'h7F8, 0, 0);
        addEntry("sw", sType(3'h2, 4, 1, -20), 0, opSw, 0, 32'hFFFFF7EC, 0, 0);
        addEntry("sb", sType(3'h0, 3, 2, 32'h123), 0, opSb, 0, 32'h922, 0, 0);
        addEntry("unknown", 32'h0000007F, 0, opNop, 0, 0, 0, 0);
        // Read every register back through rs1 without writing
        for (int r = 0; r < 26; r++) begin
            addEntry($sformatf("read x%0d", r), iType(opcodeArithI, 3'h0, 0, r, 0), 0, opAddi,
                     0, model[r], 0, 0);
        end
    endfunction

    task automatic abortRun();
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic checkEq(input string testName, input string field,
            input logic [31:0] expVal, input logic [31:0] actVal);
        if (actVal !== expVal) begin
            $display("error %s %s: expected %h actual %h", testName, field, expVal, actVal);
            abortRun();
        end
    endtask

    function automatic logic sigValue(input string sigName);
        if (sigName == "inAck") return inAck;
        return outReq;
    endfunction

    task automatic waitLevel(input string sigName, input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk); // Outputs settled here
            cycles++;
            if (cycles > timeoutCycles) begin
                $display("timeout while waiting for %s to become %0b", sigName, level);
                abortRun();
            end
        end while (sigValue(sigName) !== level);
    endtask

    // Next request only once inAck is back low
    task automatic sendInst(input vecT v);
        @(posedge clk);
        inReq  <= 1'b1;
        inInst <= v.inst;
        inPc   <= v.pc;
        waitLevel("inAck", 1'b1);
        @(posedge clk);
        inReq <= 1'b0;
        waitLevel("inAck", 1'b0);
    endtask

    task automatic takeResult(input vecT v, input int idx);
        int unsigned delay;
        waitLevel("outReq", 1'b1);
        checkEq(v.name, "op", 32'(v.op), 32'(outOp));
        checkEq(v.name, "rd", v.rd, 32'(outRd));
        checkEq(v.name, "value", v.value, outValue);
        checkEq(v.name, "taken", v.taken, 32'(outTaken));
        checkEq(v.name, "target", v.target, outTarget);
        delay = $unsigned($random(seed)) % 4;
        repeat (delay) @(posedge clk);
        @(posedge clk);
        outAck <= 1'b1;
        waitLevel("outReq", 1'b0);
        @(posedge clk);
        outAck <= 1'b0;
        checkEq(v.name, "result count", idx + 1, resultCount);
    endtask

    // Handshake ordering monitor
    always @(negedge clk) begin
        if (rstN) begin
            if (inAck && !inAckQ) begin
                if (acceptCount != doneCount) begin
                    $display("inAck rose before the previous result finished its handshake");
                    abortRun();
                end
                acceptCount++;
            end
            if (outReq && !outReqQ) resultCount++;
            if (!outAck && outAckQ) doneCount++;
        end
        inAckQ  = inAck;
        outReqQ = outReq;
        outAckQ = outAck;
    end

    initial begin
        seed   = 32'ha64;
        rstN   = 1'b0;
        inReq  = 1'b0;
        inInst = '0;
        inPc   = '0;
        outAck = 1'b0;
        buildTable();
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        // Source and sink run independently
        fork
            foreach (vecs[i]) sendInst(vecs[i]);
            foreach (vecs[i]) takeResult(vecs[i], i);
        join
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    decodedIf.consumer                 dec,
    input  logic [rvPkg::dataLen-1:0]  pc,
    input  logic [rvPkg::dataLen-1:0]  rs1Data,
    input  logic [rvPkg::dataLen-1:0]  rs2Data,
    output logic [rvPkg::dataLen-1:0]  value,
    output logic                       taken,
    output logic [rvPkg::dataLen-1:0]  target
);
    import rvPkg::*;

    logic [dataLen-1:0] opB;
    logic [dataLen-1:0] pcImm;
    logic [dataLen-1:0] link;

    assign opB   = (dec.op inside {[opAdd:opAnd]}) ? rs2Data : dec.imm; // R-type uses rs2
    assign pcImm = pc + dec.imm;
    assign link  = pc + dataLen'(4);

    always_comb begin
        value  = '0;
        taken  = 1'b0;
        target = '0;
        if (dec.op inside {opJal, [opBeq:opBgeu]}) target = pcImm;
        case (dec.op)
            opLui:   value = dec.imm;
            opAuipc: value = pcImm;
            opJal: begin
                value = link;
                taken = 1'b1;
            end
            opJalr: begin
                value  = link;
                taken  = 1'b1;
                target = (rs1Data + dec.imm) & ~dataLen'(1);
            end
            opBeq:  taken = (rs1Data == rs2Data);
            opBne:  taken = (rs1Data != rs2Data);
            opBlt:  taken = ($signed(rs1Data) < $signed(rs2Data));
            opBge:  taken = ($signed(rs1Data) >= $signed(rs2Data));
            opBltu: taken = (rs1Data < rs2Data);
            opBgeu: taken = (rs1Data >= rs2Data);
            opLb, opLh, opLw, opLbu, opLhu, opSb, opSh, opSw:
                value = rs1Data + dec.imm; // Effective address
            opAddi, opAdd:   value = rs1Data + opB;
            opSub:           value = rs1Data - opB;
            opSlti, opSlt:   value = dataLen'($signed(rs1Data) < $signed(opB));
            opSltiu, opSltu: value = dataLen'(rs1Data < opB);
            opXori, opXor:   value = rs1Data ^ opB;
            opOri, opOr:     value = rs1Data | opB;
            opAndi, opAnd:   value = rs1Data & opB;
            opSlli, opSll:   value = rs1Data << opB[4:0];
            opSrli, opSrl:   value = rs1Data >> opB[4:0];
            opSrai, opSra:   value = $signed(rs1Data) >>> opB[4:0];
            default:         value = '0;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/decodedIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodedIf;
    import rvPkg::*;

    opEnum               op;
    logic [regLen-1:0]   rd;
    logic [regLen-1:0]   rs1;
    logic [regLen-1:0]   rs2;
    logic [dataLen-1:0]  imm;

    modport producer (output op, output rd, output rs1, output rs2, output imm);
    modport consumer (input op, input rd, input rs1, input rs2, input imm);

endinterface

`default_nettype wire

// File: hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  logic [rvPkg::instLen-1:0] inst,
    decodedIf.producer                dec
);
    import rvPkg::*;

    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    opEnum              op;
    logic [regLen-1:0]  rd;
    logic [dataLen-1:0] imm;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        op  = opNop;
        rd  = inst[11:7];
        imm = '0;
        case (opcode)
            opcodeLui: begin
                op  = opLui;
                imm = {inst[31:12], 12'b0};
            end
            opcodeAuipc: begin
                op  = opAuipc;
                imm = {inst[31:12], 12'b0};
            end
            opcodeJal: begin
                op  = opJal;
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            opcodeJalr: begin
                imm = {{21{inst[31]}}, inst[30:20]};
                if (funct3 == 3'b000) op = opJalr;
            end
            opcodeLoad: begin
                imm = {{21{inst[31]}}, inst[30:20]};
                case (funct3)
                    funct3Lb:  op = opLb;
                    funct3Lh:  op = opLh;
                    funct3Lw:  op = opLw;
                    funct3Lbu: op = opLbu;
                    funct3Lhu: op = opLhu;
                    default:   op = opNop;
                endcase
            end
            opcodeStore: begin
                rd  = '0; // No destination
                imm = {{21{inst[31]}}, inst[30:25], inst[11:7]};
                case (funct3)
                    funct3Sb: op = opSb;
                    funct3Sh: op = opSh;
                    funct3Sw: op = opSw;
                    default:  op = opNop;
                endcase
            end
            opcodeBr: begin
                rd  = '0; // No destination
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                case (funct3)
                    funct3Beq:  op = opBeq;
                    funct3Bne:  op = opBne;
                    funct3Blt:  op = opBlt;
                    funct3Bge:  op = opBge;
                    funct3Bltu: op = opBltu;
                    funct3Bgeu: op = opBgeu;
                    default:    op = opNop;
                endcase
            end
            opcodeArithI: begin
                imm = {{21{inst[31]}}, inst[30:20]};
                case (funct3)
                    funct3Add:  op = opAddi;
                    funct3Slt:  op = opSlti;
                    funct3Sltu: op = opSltiu;
                    funct3Xor:  op = opXori;
                    funct3Or:   op = opOri;
                    funct3And:  op = opAndi;
                    funct3Sll:  op = (funct7 == 7'b0) ? opSlli : opNop;
                    funct3Srl: begin
                        if (funct7 == 7'b0) op = opSrli;
                        else if (funct7 == funct7Spec) op = opSrai;
                    end
                    default:    op = opNop;
                endcase
                if (op inside {opSlli, opSrli, opSrai}) imm = {27'b0, inst[24:20]}; // Shamt
            end
            opcodeArith: begin
                if (funct7 == 7'b0) begin
                    case (funct3)
                        funct3Add:  op = opAdd;
                        funct3Sll:  op = opSll;
                        funct3Slt:  op = opSlt;
                        funct3Sltu: op = opSltu;
                        funct3Xor:  op = opXor;
                        funct3Srl:  op = opSrl;
                        funct3Or:   op = opOr;
                        default:    op = opAnd;
                    endcase
                end else if (funct7 == funct7Spec) begin
                    if (funct3 == funct3Add) op = opSub;
                    else if (funct3 == funct3Srl) op = opSra;
                end
            end
            default: op = opNop;
        endcase
        if (op == opNop) imm = '0;
    end

    assign dec.op  = op;
    assign dec.rd  = rd;
    assign dec.rs1 = inst[19:15];
    assign dec.rs2 = inst[24:20];
    assign dec.imm = imm;

endmodule

`default_nettype wire

// File: hw/execCore.sv
`timescale 1ns/1ps
`default_nettype none

module execCore (
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       inReq,
    input  logic [rvPkg::instLen-1:0]  inInst,
    input  logic [rvPkg::dataLen-1:0]  inPc,
    output logic                       inAck,
    output logic                       outReq,
    input  logic                       outAck,
    output logic [5:0]                 outOp,
    output logic [rvPkg::regLen-1:0]   outRd,
    output logic [rvPkg::dataLen-1:0]  outValue,
    output logic                       outTaken,
    output logic [rvPkg::dataLen-1:0]  outTarget
);
    import rvPkg::*;

    logic [instLen-1:0] instQ;
    logic [dataLen-1:0] pcQ;
    logic [dataLen-1:0] rs1Data;
    logic [dataLen-1:0] rs2Data;
    logic [dataLen-1:0] value;
    logic [dataLen-1:0] target;
    logic               taken;
    logic               we;

    decodedIf dec ();

    decoder uDecoder (
        .inst (instQ),
        .dec  (dec.producer)
    );

    regFile uRegFile (
        .clk     (clk),
        .rstN    (rstN),
        .dec     (dec.consumer),
        .we      (we),
        .wAddr   (dec.rd),
        .wData   (value),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    alu uAlu (
        .dec     (dec.consumer),
        .pc      (pcQ),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .value   (value),
        .taken   (taken),
        .target  (target)
    );

    issueCtrl uIssueCtrl (
        .clk       (clk),
        .rstN      (rstN),
        .dec       (dec.consumer),
        .inReq     (inReq),
        .inInst    (inInst),
        .inPc      (inPc),
        .inAck     (inAck),
        .instQ     (instQ),
        .pcQ       (pcQ),
        .value     (value),
        .taken     (taken),
        .target    (target),
        .we        (we),
        .outReq    (outReq),
        .outOp     (outOp),
        .outRd     (outRd),
        .outValue  (outValue),
        .outTaken  (outTaken),
        .outTarget (outTarget),
        .outAck    (outAck)
    );

endmodule

`default_nettype wire

// File: hw/issueCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module issueCtrl (
    input  logic                       clk,
    input  logic                       rstN,
    decodedIf.consumer                 dec,
    input  logic                       inReq,
    input  logic [rvPkg::instLen-1:0]  inInst,
    input  logic [rvPkg::dataLen-1:0]  inPc,
    output logic                       inAck,
    output logic [rvPkg::instLen-1:0]  instQ,
    output logic [rvPkg::dataLen-1:0]  pcQ,
    input  logic [rvPkg::dataLen-1:0]  value,
    input  logic                       taken,
    input  logic [rvPkg::dataLen-1:0]  target,
    output logic                       we,
    output logic                       outReq,
    output rvPkg::opEnum               outOp,
    output logic [rvPkg::regLen-1:0]   outRd,
    output logic [rvPkg::dataLen-1:0]  outValue,
    output logic                       outTaken,
    output logic [rvPkg::dataLen-1:0]  outTarget,
    input  logic                       outAck
);
    import rvPkg::*;

    ctrlState state;

    // Write-back lands on the exec edge
    assign we = (state == stExec) && (dec.op inside {[opLui:opJalr], [opAddi:opAnd]})
                && (dec.rd != '0);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state     <= stIdle;
            inAck     <= 1'b0;
            outReq    <= 1'b0;
            instQ     <= '0;
            pcQ       <= '0;
            outOp     <= opNop;
            outRd     <= '0;
            outValue  <= '0;
            outTaken  <= 1'b0;
            outTarget <= '0;
        end else begin
            case (state)
                stIdle: if (inReq) begin
                    instQ <= inInst;
                    pcQ   <= inPc;
                    inAck <= 1'b1;
                    state <= stExec;
                end
                stExec: begin
                    outOp     <= dec.op;
                    outRd     <= dec.rd;
                    outValue  <= value;
                    outTaken  <= taken;
                    outTarget <= target;
                    outReq    <= 1'b1;
                    state     <= stRespond;
                end
                stRespond: if (outAck) begin
                    outReq <= 1'b0;
                    state  <= stRelease;
                end
                stRelease: if (!inReq && !outAck) begin // Both sides back to rest
                    inAck <= 1'b0;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) $fell(outReq) |-> $past(outAck));
    assert property (@(posedge clk) disable iff (!rstN) $fell(inAck) |-> !$past(inReq));

endmodule

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                       clk,
    input  logic                       rstN,
    decodedIf.consumer                 dec,
    input  logic                       we,
    input  logic [rvPkg::regLen-1:0]   wAddr,
    input  logic [rvPkg::dataLen-1:0]  wData,
    output logic [rvPkg::dataLen-1:0]  rs1Data,
    output logic [rvPkg::dataLen-1:0]  rs2Data
);
    import rvPkg::*;

    logic [dataLen-1:0] regs [31:1]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wAddr != '0) begin
            regs[wAddr] <= wData;
        end
    end

    assign rs1Data = (dec.rs1 == '0) ? '0 : regs[dec.rs1];
    assign rs2Data = (dec.rs2 == '0) ? '0 : regs[dec.rs2];

    // Controller must hold off write-back while reset is applied
    assert property (@(posedge clk) !rstN |-> we !== 1'b1);

endmodule

`default_nettype wire

// File: hw/rvPkg.sv
`default_nettype none

package rvPkg;

    localparam int instLen = 32;
    localparam int dataLen = 32;
    localparam int regLen  = 5;

    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeAuipc  = 7'b0010111;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeJalr   = 7'b1100111;
    localparam logic [6:0] opcodeBr     = 7'b1100011;
    localparam logic [6:0] opcodeLoad   = 7'b0000011;
    localparam logic [6:0] opcodeStore  = 7'b0100011;
    localparam logic [6:0] opcodeArithI = 7'b0010011;
    localparam logic [6:0] opcodeArith  = 7'b0110011;

    localparam logic [2:0] funct3Beq  = 3'b000;
    localparam logic [2:0] funct3Bne  = 3'b001;
    localparam logic [2:0] funct3Blt  = 3'b100;
    localparam logic [2:0] funct3Bge  = 3'b101;
    localparam logic [2:0] funct3Bltu = 3'b110;
    localparam logic [2:0] funct3Bgeu = 3'b111;

    localparam logic [2:0] funct3Lb  = 3'b000;
    localparam logic [2:0] funct3Lh  = 3'b001;
    localparam logic [2:0] funct3Lw  = 3'b010;
    localparam logic [2:0] funct3Lbu = 3'b100;
    localparam logic [2:0] funct3Lhu = 3'b101;
    localparam logic [2:0] funct3Sb  = 3'b000;
    localparam logic [2:0] funct3Sh  = 3'b001;
    localparam logic [2:0] funct3Sw  = 3'b010;

    // Shared by I-type and R-type arithmetic
    localparam logic [2:0] funct3Add  = 3'b000;
    localparam logic [2:0] funct3Sll  = 3'b001;
    localparam logic [2:0] funct3Slt  = 3'b010;
    localparam logic [2:0] funct3Sltu = 3'b011;
    localparam logic [2:0] funct3Xor  = 3'b100;
    localparam logic [2:0] funct3Srl  = 3'b101;
    localparam logic [2:0] funct3Or   = 3'b110;
    localparam logic [2:0] funct3And  = 3'b111;

    localparam logic [6:0] funct7Spec = 7'b0100000; // SUB, SRA, SRAI

    // Groups must stay contiguous, range checks depend on it
    typedef enum logic [5:0] {
        opNop, opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opLb, opLh, opLw, opLbu, opLhu,
        opSb, opSh, opSw,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd
    } opEnum;

    typedef enum logic [1:0] {
        stIdle, stExec, stRespond, stRelease
    } ctrlState;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module execCoreTb -f src.f -o simv

# The sim status is masked by tee, the log decides
./obj_dir/simv | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation PASSED"

// File: src.f
hw/rvPkg.sv
hw/decodedIf.sv
hw/decoder.sv
hw/regFile.sv
hw/alu.sv
hw/issueCtrl.sv
hw/execCore.sv
dv/execCoreTb.sv
